//--- design/sb_alu_unit.sv
`timescale 1ns/1ns
`include "sb_defines.svh"

module sb_alu_unit (
    input  logic                clk,
    input  logic                resetn,
    input  logic                issue_go,
    input  sb_pkg::alu_op_e     op,
    input  logic                use_imm,
    input  logic [`SB_XLEN-1:0] imm,
    input  logic [`SB_XLEN-1:0] rdata1,
    input  logic [`SB_XLEN-1:0] rdata2,
    output logic                done,
    output logic [`SB_XLEN-1:0] result
);

    sb_pkg::alu_op_e     op_q;
    logic [`SB_XLEN-1:0] opa;
    logic [`SB_XLEN-1:0] opb;

    always_ff @(posedge clk) begin
        if (!resetn)
            done <= 1'b0;
        else
            done <= issue_go;
    end

    // operands captured at issue
    always_ff @(posedge clk) begin
        if (issue_go) begin
            op_q <= op;
            opa  <= rdata1;
            opb  <= use_imm ? imm : rdata2;
        end
    end

    always_comb begin
        case (op_q)
            sb_pkg::OP_ADD: result = opa + opb;
            sb_pkg::OP_SUB: result = opa - opb;
            sb_pkg::OP_AND: result = opa & opb;
            sb_pkg::OP_OR:  result = opa | opb;
            sb_pkg::OP_XOR: result = opa ^ opb;
            sb_pkg::OP_SLT: result = {{(`SB_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            // shift amount from low five bits
            sb_pkg::OP_SLL: result = opa << opb[4:0];
            sb_pkg::OP_SRL: result = opa >> opb[4:0];
            default:        result = '0;
        endcase
    end

endmodule

//--- design/sb_core.sv
`timescale 1ns/1ns
`include "sb_defines.svh"

module sb_core (
    input  logic            clk,
    input  logic            resetn,
    input  logic            inst_valid,
    input  sb_pkg::inst_t   inst,
    output logic            stall,
    output logic            retire_valid,
    output sb_pkg::retire_t retire
);

    logic                                   dispatch_pending;
    logic                                   dispatch_go;
    sb_pkg::inst_t                          dispatch_inst;
    sb_pkg::fu_track_t [`SB_NUM_FU-1:0]     track;
    logic [`SB_NUM_FU-1:0]                  issue_go;
    sb_pkg::alu_op_e [`SB_NUM_FU-1:0]       issue_op;
    logic [`SB_NUM_FU-1:0]                  issue_use_imm;
    logic [`SB_NUM_FU-1:0][`SB_XLEN-1:0]    issue_imm;
    logic [`SB_NUM_FU-1:0]                  done;
    logic [`SB_NUM_FU-1:0][`SB_XLEN-1:0]    result;
    logic [`SB_NUM_FU-1:0]                  wb_ok;
    logic [`SB_NUM_FU-1:0][`SB_REG_W-1:0]   raddr1;
    logic [`SB_NUM_FU-1:0][`SB_REG_W-1:0]   raddr2;
    logic [`SB_NUM_FU-1:0][`SB_XLEN-1:0]    rdata1;
    logic [`SB_NUM_FU-1:0][`SB_XLEN-1:0]    rdata2;

    sb_window u_window (
        .clk              (clk),
        .resetn           (resetn),
        .inst_valid       (inst_valid),
        .inst             (inst),
        .stall            (stall),
        .dispatch_pending (dispatch_pending),
        .dispatch_inst    (dispatch_inst),
        .dispatch_go      (dispatch_go),
        .track            (track),
        .issue_go         (issue_go),
        .done             (done),
        .result           (result),
        .wb_ok            (wb_ok),
        .retire_valid     (retire_valid),
        .retire           (retire)
    );

    sb_status u_status (
        .clk              (clk),
        .resetn           (resetn),
        .dispatch_pending (dispatch_pending),
        .dispatch_inst    (dispatch_inst),
        .dispatch_go      (dispatch_go),
        .track            (track),
        .issue_go         (issue_go),
        .issue_op         (issue_op),
        .issue_use_imm    (issue_use_imm),
        .issue_imm        (issue_imm),
        .wb_ok            (wb_ok),
        .retire_valid     (retire_valid),
        .retire           (retire)
    );

    for (genvar u = 0; u < `SB_NUM_FU; u++) begin : g_alu
        // operand reads follow the unit track
        assign raddr1[u] = track[u].src1;
        assign raddr2[u] = track[u].src2;

        sb_alu_unit u_alu (
            .clk      (clk),
            .resetn   (resetn),
            .issue_go (issue_go[u]),
            .op       (issue_op[u]),
            .use_imm  (issue_use_imm[u]),
            .imm      (issue_imm[u]),
            .rdata1   (rdata1[u]),
            .rdata2   (rdata2[u]),
            .done     (done[u]),
            .result   (result[u])
        );
    end

    sb_regfile u_regfile (
        .clk          (clk),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

//--- design/sb_defines.svh
`ifndef SB_DEFINES_SVH
`define SB_DEFINES_SVH

// instruction window
`define SB_WINDOW_DEPTH 16
`define SB_IDX_W        $clog2(`SB_WINDOW_DEPTH)

// occupancy that raises stall
`define SB_STALL_LEVEL  12

// architectural registers, register 0 reads zero
`define SB_REG_COUNT    32
`define SB_REG_W        $clog2(`SB_REG_COUNT)

// data and pc width
`define SB_XLEN         32

// alu functional units
`define SB_NUM_FU       2
`define SB_FU_IDX_W     $clog2(`SB_NUM_FU)

`endif

//--- design/sb_pkg.sv
`include "sb_defines.svh"

package sb_pkg;

    // unit selector, also used as producer tag
    typedef enum logic [1:0] {
        FU_ALU0,
        FU_ALU1,
        FU_NONE
    } fu_e;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL
    } alu_op_e;

    typedef struct packed {
        logic [`SB_XLEN-1:0]  pc;
        fu_e                  fu;
        alu_op_e              op;
        logic [`SB_REG_W-1:0] dst;
        logic [`SB_REG_W-1:0] src1;
        logic                 src1_used;
        logic [`SB_REG_W-1:0] src2;
        logic                 src2_used;
        // operand 2 when src2_used is low
        logic [`SB_XLEN-1:0]  imm;
    } inst_t;

    typedef struct packed {
        logic [`SB_XLEN-1:0]  pc;
        fu_e                  fu;
        logic [`SB_REG_W-1:0] dst;
        logic [`SB_XLEN-1:0]  data;
    } retire_t;

    typedef struct packed {
        logic                 busy;
        logic [`SB_IDX_W-1:0] slot;
        logic [`SB_REG_W-1:0] dst;
        logic [`SB_REG_W-1:0] src1;
        logic                 src1_used;
        logic [`SB_REG_W-1:0] src2;
        logic                 src2_used;
        fu_e                  tag1;
        fu_e                  tag2;
    } fu_track_t;

endpackage

//--- design/sb_regfile.sv
`timescale 1ns/1ns
`include "sb_defines.svh"

module sb_regfile (
    input  logic                                    clk,
    input  logic [`SB_NUM_FU-1:0][`SB_REG_W-1:0]    raddr1,
    input  logic [`SB_NUM_FU-1:0][`SB_REG_W-1:0]    raddr2,
    output logic [`SB_NUM_FU-1:0][`SB_XLEN-1:0]     rdata1,
    output logic [`SB_NUM_FU-1:0][`SB_XLEN-1:0]     rdata2,
    input  logic                                    retire_valid,
    input  sb_pkg::retire_t                         retire
);

    logic [`SB_XLEN-1:0] regs [`SB_REG_COUNT];

    // single write port at retire
    always_ff @(posedge clk) begin
        if (retire_valid && retire.dst != '0)
            regs[retire.dst] <= retire.data;
    end

    always_comb begin
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            rdata1[u] = (raddr1[u] == '0) ? '0 : regs[raddr1[u]];
            rdata2[u] = (raddr2[u] == '0) ? '0 : regs[raddr2[u]];
        end
    end

endmodule

//--- design/sb_status.sv
`timescale 1ns/1ns
`include "sb_defines.svh"

module sb_status (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    dispatch_pending,
    input  sb_pkg::inst_t                           dispatch_inst,
    output logic                                    dispatch_go,
    output sb_pkg::fu_track_t [`SB_NUM_FU-1:0]      track,
    output logic [`SB_NUM_FU-1:0]                   issue_go,
    output sb_pkg::alu_op_e [`SB_NUM_FU-1:0]        issue_op,
    output logic [`SB_NUM_FU-1:0]                   issue_use_imm,
    output logic [`SB_NUM_FU-1:0][`SB_XLEN-1:0]     issue_imm,
    output logic [`SB_NUM_FU-1:0]                   wb_ok,
    input  logic                                    retire_valid,
    input  sb_pkg::retire_t                         retire
);

    localparam sb_pkg::fu_track_t TRACK_IDLE = '{
        busy:      1'b0,
        slot:      '0,
        dst:       '0,
        src1:      '0,
        src1_used: 1'b0,
        src2:      '0,
        src2_used: 1'b0,
        tag1:      sb_pkg::FU_NONE,
        tag2:      sb_pkg::FU_NONE
    };

    // pending producer per register
    sb_pkg::fu_e               reg_status [`SB_REG_COUNT];
    logic [`SB_NUM_FU-1:0]     issued;
    // mirrors the window dispatch pointer
    logic [`SB_IDX_W-1:0]      disp_slot;
    logic [`SB_FU_IDX_W-1:0]   disp_unit;
    logic [`SB_FU_IDX_W-1:0]   ret_unit;
    sb_pkg::fu_e               tag1_new;
    sb_pkg::fu_e               tag2_new;

    assign disp_unit = dispatch_inst.fu[`SB_FU_IDX_W-1:0];
    assign ret_unit  = retire.fu[`SB_FU_IDX_W-1:0];

    // waw and structural check
    assign dispatch_go = dispatch_pending
                         && dispatch_inst.fu != sb_pkg::FU_NONE
                         && !track[disp_unit].busy
                         && reg_status[dispatch_inst.dst] == sb_pkg::FU_NONE;

    // a register retiring this cycle counts as free
    always_comb begin
        tag1_new = reg_status[dispatch_inst.src1];
        tag2_new = reg_status[dispatch_inst.src2];
        if (!dispatch_inst.src1_used || (retire_valid && retire.dst == dispatch_inst.src1))
            tag1_new = sb_pkg::FU_NONE;
        if (!dispatch_inst.src2_used || (retire_valid && retire.dst == dispatch_inst.src2))
            tag2_new = sb_pkg::FU_NONE;
    end

    always_comb begin
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            issue_go[u] = track[u].busy && !issued[u]
                          && track[u].tag1 == sb_pkg::FU_NONE
                          && track[u].tag2 == sb_pkg::FU_NONE;
            // war: hold while another unit has yet to read the old value
            wb_ok[u] = 1'b1;
            for (int v = 0; v < `SB_NUM_FU; v++) begin
                if (v != u && track[v].busy && !issued[v]) begin
                    if (track[v].src1_used && track[v].src1 == track[u].dst
                        && track[v].tag1 != sb_pkg::fu_e'(u))
                        wb_ok[u] = 1'b0;
                    if (track[v].src2_used && track[v].src2 == track[u].dst
                        && track[v].tag2 != sb_pkg::fu_e'(u))
                        wb_ok[u] = 1'b0;
                end
            end
            if (track[u].dst == '0)
                wb_ok[u] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int r = 0; r < `SB_REG_COUNT; r++)
                reg_status[r] <= sb_pkg::FU_NONE;
            for (int u = 0; u < `SB_NUM_FU; u++)
                track[u] <= TRACK_IDLE;
            issued    <= '0;
            disp_slot <= '0;
        end else begin
            for (int u = 0; u < `SB_NUM_FU; u++) begin
                if (issue_go[u])
                    issued[u] <= 1'b1;
            end
            // release unit and wake its consumers
            if (retire_valid) begin
                reg_status[retire.dst] <= sb_pkg::FU_NONE;
                for (int u = 0; u < `SB_NUM_FU; u++) begin
                    if (track[u].tag1 == retire.fu)
                        track[u].tag1 <= sb_pkg::FU_NONE;
                    if (track[u].tag2 == retire.fu)
                        track[u].tag2 <= sb_pkg::FU_NONE;
                end
                track[ret_unit] <= TRACK_IDLE;
                issued[ret_unit] <= 1'b0;
            end
            if (dispatch_go) begin
                track[disp_unit] <= '{
                    busy:      1'b1,
                    slot:      disp_slot,
                    dst:       dispatch_inst.dst,
                    src1:      dispatch_inst.src1_used ? dispatch_inst.src1 : '0,
                    src1_used: dispatch_inst.src1_used,
                    src2:      dispatch_inst.src2_used ? dispatch_inst.src2 : '0,
                    src2_used: dispatch_inst.src2_used,
                    tag1:      tag1_new,
                    tag2:      tag2_new
                };
                issued[disp_unit] <= 1'b0;
                if (dispatch_inst.dst != '0)
                    reg_status[dispatch_inst.dst] <= dispatch_inst.fu;
                disp_slot <= disp_slot + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_go) begin
            issue_op[disp_unit]      <= dispatch_inst.op;
            issue_use_imm[disp_unit] <= !dispatch_inst.src2_used;
            issue_imm[disp_unit]     <= dispatch_inst.imm;
        end
    end

endmodule

//--- design/sb_window.sv
`timescale 1ns/1ns
`include "sb_defines.svh"

module sb_window (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    inst_valid,
    input  sb_pkg::inst_t                           inst,
    output logic                                    stall,
    output logic                                    dispatch_pending,
    output sb_pkg::inst_t                           dispatch_inst,
    input  logic                                    dispatch_go,
    input  sb_pkg::fu_track_t [`SB_NUM_FU-1:0]      track,
    input  logic [`SB_NUM_FU-1:0]                   issue_go,
    input  logic [`SB_NUM_FU-1:0]                   done,
    input  logic [`SB_NUM_FU-1:0][`SB_XLEN-1:0]     result,
    input  logic [`SB_NUM_FU-1:0]                   wb_ok,
    output logic                                    retire_valid,
    output sb_pkg::retire_t                         retire
);

    sb_pkg::inst_t               entry_inst [`SB_WINDOW_DEPTH];
    logic [`SB_XLEN-1:0]         entry_data [`SB_WINDOW_DEPTH];

    // per-entry stage flags
    logic [`SB_WINDOW_DEPTH-1:0] valid_flag;
    logic [`SB_WINDOW_DEPTH-1:0] disp_flag;
    logic [`SB_WINDOW_DEPTH-1:0] issue_flag;
    logic [`SB_WINDOW_DEPTH-1:0] exec_flag;
    logic [`SB_WINDOW_DEPTH-1:0] wb_flag;

    // extra msb on write and read pointers for wrap
    logic [`SB_IDX_W:0]          wr_ptr;
    logic [`SB_IDX_W:0]          rd_ptr;
    logic [`SB_IDX_W:0]          occupancy;
    logic [`SB_IDX_W-1:0]        disp_ptr;
    logic [`SB_IDX_W-1:0]        wr_idx;
    logic [`SB_IDX_W-1:0]        rd_idx;
    logic                        accept;

    assign wr_idx    = wr_ptr[`SB_IDX_W-1:0];
    assign rd_idx    = rd_ptr[`SB_IDX_W-1:0];
    assign occupancy = wr_ptr - rd_ptr;
    assign stall     = occupancy >= `SB_STALL_LEVEL;
    assign accept    = inst_valid && !stall;

    assign dispatch_inst    = entry_inst[disp_ptr];
    assign dispatch_pending = valid_flag[disp_ptr] && !disp_flag[disp_ptr];

    // head retires once written back
    assign retire_valid = valid_flag[rd_idx] && wb_flag[rd_idx];
    assign retire.pc    = entry_inst[rd_idx].pc;
    assign retire.fu    = entry_inst[rd_idx].fu;
    assign retire.dst   = entry_inst[rd_idx].dst;
    assign retire.data  = entry_data[rd_idx];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            disp_ptr <= '0;
        end else begin
            if (accept)
                wr_ptr <= wr_ptr + 1'b1;
            if (dispatch_go)
                disp_ptr <= disp_ptr + 1'b1;
            if (retire_valid)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_flag <= '0;
            disp_flag  <= '0;
            issue_flag <= '0;
            exec_flag  <= '0;
            wb_flag    <= '0;
        end else begin
            if (accept)
                valid_flag[wr_idx] <= 1'b1;
            if (dispatch_go)
                disp_flag[disp_ptr] <= 1'b1;
            for (int u = 0; u < `SB_NUM_FU; u++) begin
                if (issue_go[u])
                    issue_flag[track[u].slot] <= 1'b1;
                if (done[u] && issue_flag[track[u].slot])
                    exec_flag[track[u].slot] <= 1'b1;
                if (wb_ok[u] && track[u].busy && exec_flag[track[u].slot])
                    wb_flag[track[u].slot] <= 1'b1;
            end
            // head entry leaves, all flags drop
            if (retire_valid) begin
                valid_flag[rd_idx] <= 1'b0;
                disp_flag[rd_idx]  <= 1'b0;
                issue_flag[rd_idx] <= 1'b0;
                exec_flag[rd_idx]  <= 1'b0;
                wb_flag[rd_idx]    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            entry_inst[wr_idx] <= inst;
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            if (done[u])
                entry_data[track[u].slot] <= result[u];
        end
    end

endmodule

//--- dv/sb_core_asserts.sv
`timescale 1ns/1ns
`include "sb_defines.svh"

module sb_core_asserts (
    input logic                               clk,
    input logic                               resetn,
    input logic [`SB_IDX_W:0]                 occupancy,
    input logic [`SB_IDX_W:0]                 wr_ptr,
    input logic [`SB_WINDOW_DEPTH-1:0]        wb_flag,
    input logic [`SB_IDX_W-1:0]               rd_idx,
    input sb_pkg::fu_track_t [`SB_NUM_FU-1:0] track,
    input logic                               stall,
    input logic                               retire_valid,
    input sb_pkg::retire_t                    retire
);

    int                      fail_count = 0;
    logic [`SB_FU_IDX_W-1:0] ret_unit;

    assign ret_unit = retire.fu[`SB_FU_IDX_W-1:0];

    a_occupancy: assert property (@(posedge clk) disable iff (!resetn)
        occupancy <= `SB_WINDOW_DEPTH)
    else begin
        fail_count++;
        $error("window occupancy %0d above depth", occupancy);
    end

    // head must be written back and still held by its unit
    a_retire_wb: assert property (@(posedge clk) disable iff (!resetn)
        retire_valid |-> wb_flag[rd_idx] && track[ret_unit].busy
                         && track[ret_unit].slot == rd_idx)
    else begin
        fail_count++;
        $error("retire pulse for entry %0d without writeback flag or unit track", rd_idx);
    end

    a_no_accept_on_stall: assert property (@(posedge clk) disable iff (!resetn)
        stall |=> $stable(wr_ptr))
    else begin
        fail_count++;
        $error("write pointer moved while stall was high");
    end

endmodule

bind sb_window sb_core_asserts u_asserts (
    .clk          (clk),
    .resetn       (resetn),
    .occupancy    (occupancy),
    .wr_ptr       (wr_ptr),
    .wb_flag      (wb_flag),
    .rd_idx       (rd_idx),
    .track        (track),
    .stall        (stall),
    .retire_valid (retire_valid),
    .retire       (retire)
);

//--- dv/sb_core_tb.sv
`timescale 1ns/1ns
`include "sb_defines.svh"

module sb_core_tb;

    localparam int INIT_N  = `SB_REG_COUNT - 1;
    localparam int INDEP_N = 32;
    localparam int RAW_N   = 16;
    localparam int REUSE_N = 16;
    localparam int BURST_N = 40;
    localparam int RAND_N  = 200;
    localparam int CYCLE_LIMIT = 60 * (INIT_N + INDEP_N + RAW_N + REUSE_N + BURST_N + RAND_N);

    logic                clk = 1'b0;
    logic                resetn;
    logic                inst_valid;
    sb_pkg::inst_t       inst;
    logic                stall;
    logic                retire_valid;
    sb_pkg::retire_t     retire;

    sb_pkg::inst_t       accepted_q[$];
    logic [`SB_XLEN-1:0] model_regs [`SB_REG_COUNT];
    logic [`SB_XLEN-1:0] pc_next;
    string               cur_test;
    logic                stall_seen;
    int                  errors = 0;
    int                  checks = 0;
    int                  tests_run = 0;
    int                  accepted_total = 0;
    int                  retired_total = 0;
    int                  test_err_start;
    int                  test_ret_start;
    int                  cycles;

    sb_core dut0 (
        .clk          (clk),
        .resetn       (resetn),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #10 clk = ~clk;

    function automatic sb_pkg::inst_t make_inst(input int unit, input int op, input int dst,
                                                input int src1, input int s1u, input int src2,
                                                input int s2u, input logic [`SB_XLEN-1:0] imm);
        sb_pkg::inst_t i;
        i = '0;
        i.fu        = unit[0] ? sb_pkg::FU_ALU1 : sb_pkg::FU_ALU0;
        i.op        = sb_pkg::alu_op_e'(op[2:0]);
        i.dst       = dst[`SB_REG_W-1:0];
        i.src1      = src1[`SB_REG_W-1:0];
        i.src1_used = s1u != 0;
        i.src2      = src2[`SB_REG_W-1:0];
        i.src2_used = s2u != 0;
        i.imm       = imm;
        return i;
    endfunction

    // program-order model, register 0 never written
    function automatic sb_pkg::retire_t ref_retire(input sb_pkg::inst_t i);
        logic [`SB_XLEN-1:0] a;
        logic [`SB_XLEN-1:0] b;
        logic [`SB_XLEN-1:0] r;
        sb_pkg::retire_t     rt;
        a = i.src1_used ? model_regs[i.src1] : '0;
        b = i.src2_used ? model_regs[i.src2] : i.imm;
        case (i.op)
            sb_pkg::OP_ADD: r = a + b;
            sb_pkg::OP_SUB: r = a - b;
            sb_pkg::OP_AND: r = a & b;
            sb_pkg::OP_OR:  r = a | b;
            sb_pkg::OP_XOR: r = a ^ b;
            sb_pkg::OP_SLT: r = ($signed(a) < $signed(b)) ? 1 : 0;
            sb_pkg::OP_SLL: r = a << b[4:0];
            default:        r = a >> b[4:0];
        endcase
        if (i.dst != '0)
            model_regs[i.dst] = r;
        rt.pc   = i.pc;
        rt.fu   = i.fu;
        rt.dst  = i.dst;
        rt.data = r;
        return rt;
    endfunction

    task automatic compare_field(input string field, input logic [`SB_XLEN-1:0] exp_val,
                                 input logic [`SB_XLEN-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("Error: %s %s expected %h actual %h", cur_test, field, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic check_quiet_outputs();
        if (stall !== 1'b0) begin
            $display("Error: %s stall expected 0 actual %b", cur_test, stall);
            errors++;
        end
        if (retire_valid !== 1'b0) begin
            $display("Error: %s retire_valid expected 0 actual %b", cur_test, retire_valid);
            errors++;
        end
    endtask

    // called on a rising edge, returns on the edge that accepts
    task automatic send(input sb_pkg::inst_t i);
        i.pc = pc_next;
        pc_next = pc_next + 4;
        inst_valid <= 1'b1;
        inst <= i;
        @(negedge clk);
        while (stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        accepted_q.push_back(i);
        accepted_total++;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_start = errors;
        test_ret_start = retired_total;
    endtask

    task automatic end_test();
        inst_valid <= 1'b0;
        while (retired_total != accepted_total)
            @(posedge clk);
        tests_run++;
        $display("%s: %0d retired, %0d errors", cur_test, retired_total - test_ret_start,
                 errors - test_err_start);
    endtask

    always @(negedge clk) begin
        sb_pkg::retire_t exp_rt;
        logic            exp_stall;
        if (resetn === 1'b1) begin
            // window holds accepted minus retired entries
            exp_stall = (accepted_total - retired_total) >= `SB_STALL_LEVEL;
            if (stall !== exp_stall) begin
                $display("Error: %s stall expected %b actual %b", cur_test, exp_stall, stall);
                errors++;
            end
        end
        if (resetn === 1'b1 && retire_valid === 1'b1) begin
            if (accepted_q.size() == 0) begin
                $display("%s: retire pulse with no accepted instruction left, pc %h",
                         cur_test, retire.pc);
                errors++;
            end else begin
                exp_rt = ref_retire(accepted_q.pop_front());
                checks++;
                compare_field("pc", exp_rt.pc, retire.pc);
                compare_field("fu", `SB_XLEN'(exp_rt.fu), `SB_XLEN'(retire.fu));
                compare_field("dst", `SB_XLEN'(exp_rt.dst), `SB_XLEN'(retire.dst));
                compare_field("data", exp_rt.data, retire.data);
                retired_total++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin
        int fu_r;
        int op_r;
        int dst_r;
        int s1_r;
        int s2_r;
        int use_r;
        int imm_r;
        void'($urandom(32'h586eb101));
        resetn     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc_next    = 32'h0000_1000;
        for (int r = 0; r < `SB_REG_COUNT; r++)
            model_regs[r] = '0;

        start_test("reset");
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            if (c == 3)
                resetn <= 1'b1;
            @(negedge clk);
            check_quiet_outputs();
        end
        // first cycle out of reset
        @(posedge clk);
        @(negedge clk);
        check_quiet_outputs();
        @(posedge clk);
        end_test();

        start_test("reg_init");
        for (int r = 1; r < `SB_REG_COUNT; r++)
            send(make_inst(r % 2, sb_pkg::OP_ADD, r, 0, 0, 0, 0, r * 32'h0951_3a27));
        end_test();

        // each op with and without immediate on both units
        start_test("indep");
        for (int k = 0; k < INDEP_N; k++)
            send(make_inst(k % 2, k / 4, 16 + k % 8, 1 + k % 15, 1, 2 + k % 13, (k / 2) % 2,
                           32'h0f0f_0000 + k * 32'h1357));
        end_test();

        start_test("raw_chain");
        for (int k = 0; k < RAW_N; k++)
            send(make_inst(k % 2, sb_pkg::OP_ADD, 24 + k % 4, 24 + (k + 3) % 4, k != 0, 0, 0,
                           (k == 0) ? 100 : 1));
        end_test();

        start_test("war_waw");
        for (int k = 0; k < REUSE_N / 4; k++) begin
            send(make_inst(0, sb_pkg::OP_ADD, 5, 6, 1, 7, 1, '0));
            send(make_inst(1, sb_pkg::OP_ADD, 6, 5, 1, 0, 0, k + 1));
            // result retires but register 0 keeps zero
            send(make_inst(0, sb_pkg::OP_SUB, 0, 6, 1, 5, 1, '0));
            send(make_inst(1, sb_pkg::OP_OR, 7, 0, 1, 0, 0, 32'h100 * (k + 1)));
        end
        end_test();

        start_test("burst");
        stall_seen = 1'b0;
        for (int k = 0; k < BURST_N; k++)
            send(make_inst(k % 2, k % 8, 8 + k % 8, 1 + k % 7, 1, 9 + k % 5, k % 3 == 0,
                           32'h11 * k));
        if (!stall_seen) begin
            $display("burst: stall never went high during the burst");
            errors++;
        end
        end_test();

        start_test("random");
        for (int k = 0; k < RAND_N; k++) begin
            if ($urandom % 4 == 0) begin
                inst_valid <= 1'b0;
                @(posedge clk);
            end
            fu_r  = $urandom;
            op_r  = $urandom;
            dst_r = $urandom;
            s1_r  = $urandom;
            s2_r  = $urandom;
            use_r = $urandom;
            imm_r = $urandom;
            send(make_inst(fu_r, op_r, dst_r, s1_r, use_r & 1, s2_r, (use_r >> 1) & 1, imm_r));
        end
        end_test();

        // quiet period to catch any stray retire
        repeat (10) @(posedge clk);
        $display("tests %0d, accepted %0d, retired %0d, checks %0d, errors %0d, assert fails %0d",
                 tests_run, accepted_total, retired_total, checks, errors,
                 dut0.u_window.u_asserts.fail_count);
        if (errors == 0 && dut0.u_window.u_asserts.fail_count == 0 && accepted_q.size() == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- sb_core.f
+incdir+design
design/sb_pkg.sv
design/sb_alu_unit.sv
design/sb_regfile.sv
design/sb_window.sv
design/sb_status.sv
design/sb_core.sv
dv/sb_core_asserts.sv
dv/sb_core_tb.sv
